// ==== compile.f ====
source/dispatch_pkg.sv
source/sample_fifo.sv
source/route_config.sv
source/instr_dispatch.sv
source/dispatch_top.sv
verif/dispatch_chk.sv
verif/dispatch_tb.sv

// ==== verif/dispatch_tb.sv ====
`timescale 1ns/1ps

// Testbench for the dispatch stage with a cycle model of the FIFO and dispatcher
module dispatch_tb import dispatch_pkg::*; ();

   localparam int n_burst = 40;
   localparam int n_flood = fifo_depth + 8;
   localparam int total_samples = 2 * n_burst + n_flood;
   // Two routing passes of 2*n_chan+2 writes each, counted generously
   localparam int cfg_cycles = 2 * (4 * n_chan + 2);
   // Gaps between samples, drain waits and the last reset fit in the margin
   localparam int timeout_cycles = total_samples * (n_chan + 1) + cfg_cycles + 400;

   logic                 clk_in;
   logic                 rst_n;
   logic                 dv_in;
   logic [w_src-1:0]     src_in;
   logic [w_data-1:0]    data_in;
   logic                 wr_en;
   logic [w_wr_addr-1:0] wr_addr;
   logic [w_chan-1:0]    wr_chan;
   logic [w_wr_data-1:0] wr_data;
   logic                 dv_out;
   logic [w_chan:0]      chan_out;
   logic [w_data-1:0]    data_out;
   logic                 overflow;

   // Mirror of the routing memory
   logic [w_src:0]    sel_m [n_chan];
   logic [n_chan-1:0] en_m;

   // Accepted samples, and the instructions they are expected to produce
   logic [w_src-1:0]  fifo_m [$];
   logic [w_chan:0]   exp_chan [$];
   logic [w_data-1:0] exp_data [$];

   int   head_pos;
   logic pop_now;
   logic ovf_m;
   int   sb_errors = 0;
   int   chk_errors;
   int   cycles = 0;

   dispatch_top uut (.*);

   bind instr_dispatch dispatch_chk u_chk (
      .clk_in       (clk_in),
      .rst_n        (rst_n),
      .fifo_valid   (fifo_valid),
      .fifo_src     (fifo_src),
      .src_sel_flat (src_sel_flat),
      .chan_en      (chan_en),
      .fifo_pop     (fifo_pop),
      .dv_out       (dv_out),
      .chan_out     (chan_out)
   );

   always #5 clk_in = ~clk_in;

   // Channels listening to a source, disabled ones included since they cost a cycle
   function automatic int route_count(input logic [w_src-1:0] src);
      int n;
      n = 0;
      for (int c = 0; c < n_chan; c++) begin
         if (sel_m[c] == {1'b0, src}) begin
            n++;
         end
      end
      return n;
   endfunction

   // ------------------------------
   // Model and scoreboard
   // ------------------------------

   always @(posedge clk_in) begin
      if (!rst_n) begin
         fifo_m.delete();
         exp_chan.delete();
         exp_data.delete();
         head_pos = 0;
         ovf_m = 1'b0;
      end else begin
         if (dv_out && exp_chan.size() == 0) begin
            $display("mismatch at %0t: dv_out on channel %0d, none expected", $time, chan_out);
            sb_errors++;
         end else if (dv_out) begin
            assert (chan_out == exp_chan[0] && data_out == exp_data[0]) else begin
               $display("mismatch at %0t: channel %0d data %h, expected channel %0d data %h",
                        $time, chan_out, data_out, exp_chan[0], exp_data[0]);
               sb_errors++;
            end
            exp_chan.delete(0);
            exp_data.delete(0);
         end
         assert (overflow == ovf_m) else begin
            $display("mismatch at %0t: overflow %b, expected %b", $time, overflow, ovf_m);
            sb_errors++;
         end
         // The head takes one cycle per routed channel, then one pop cycle
         pop_now = 1'b0;
         if (fifo_m.size() != 0) begin
            if (head_pos < route_count(fifo_m[0])) begin
               head_pos++;
            end else begin
               pop_now = 1'b1;
               head_pos = 0;
            end
         end
         // Fullness is judged before this edge's pop
         if (dv_in && fifo_m.size() < fifo_depth) begin
            fifo_m.push_back(src_in);
            for (int c = 0; c < n_chan; c++) begin
               if (sel_m[c] == {1'b0, src_in} && en_m[c]) begin
                  exp_chan.push_back((w_chan + 1)'(c));
                  exp_data.push_back(data_in);
               end
            end
         end else if (dv_in) begin
            ovf_m = 1'b1;
         end
         if (pop_now) begin
            fifo_m.delete(0);
         end
      end
   end

   always @(posedge clk_in) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("Regression failed");
         $finish;
      end
   end

   // ------------------------------
   // Stimulus
   // ------------------------------

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk_in);
         dv_in <= 1'b0;
         wr_en <= 1'b0;
      end
   endtask

   task automatic write_reg(input logic [w_wr_addr-1:0] addr, input int chan,
                            input logic [w_wr_data-1:0] data);
      @(posedge clk_in);
      wr_en   <= 1'b1;
      wr_addr <= addr;
      wr_chan <= w_chan'(chan);
      wr_data <= data;
      if (addr == src_sel_addr) begin
         sel_m[chan] = data[w_src:0];
      end else if (addr == chan_en_addr) begin
         en_m[chan] = data[0];
      end
   endtask

   // The first n_shared channels listen to shared_src, channel 1 always ends disabled
   task automatic configure_routes(input int shared_src, input int n_shared);
      logic [w_src:0] sel;
      for (int c = 0; c < n_chan; c++) begin
         if (c < n_shared) begin
            sel = {1'b0, w_src'(shared_src)};
         end else if ($urandom_range(4, 0) == 4) begin
            sel = null_src;
         end else begin
            sel = {1'b0, w_src'($urandom_range(3, 0))};
         end
         write_reg(src_sel_addr, c, w_wr_data'(sel));
         write_reg(chan_en_addr, c, w_wr_data'($urandom_range(3, 0) != 0));
      end
      write_reg(chan_en_addr, 1, '0);
      // Unknown address, the memory must not change
      write_reg(16'd3, 0, 16'h0015);
      idle(2);
   endtask

   task automatic send_sample(input logic [w_src-1:0] src, input logic [w_data-1:0] data);
      @(posedge clk_in);
      dv_in   <= 1'b1;
      src_in  <= src;
      data_in <= data;
   endtask

   // Sources 4 and 5 are never routed
   task automatic send_burst(input int n);
      for (int i = 0; i < n; i++) begin
         send_sample(w_src'($urandom_range(5, 0)), w_data'($urandom));
         idle($urandom_range(2, 0));
      end
      idle(1);
   endtask

   task automatic wait_drain();
      while (fifo_m.size() != 0 || exp_chan.size() != 0) begin
         @(posedge clk_in);
      end
      idle(2);
   endtask

   initial begin
      void'($urandom(32'h9468_ed61));
      clk_in  = 1'b0;
      rst_n   = 1'b0;
      dv_in   = 1'b0;
      src_in  = '0;
      data_in = '0;
      wr_en   = 1'b0;
      wr_addr = '0;
      wr_chan = '0;
      wr_data = '0;
      en_m    = '0;
      for (int c = 0; c < n_chan; c++) begin
         sel_m[c] = null_src;
      end
      repeat (4) @(posedge clk_in);
      rst_n <= 1'b1;

      configure_routes(1, 2);
      send_burst(n_burst);
      wait_drain();

      // New routing applies to every sample pushed from here on
      configure_routes(2, 4);
      send_burst(n_burst);
      wait_drain();

      // Source 2 fans out to at least four channels, so back-to-back pushes overrun
      for (int i = 0; i < n_flood; i++) begin
         send_sample(w_src'(2), w_data'($urandom));
      end
      idle(1);
      wait_drain();
      assert (ovf_m) else begin
         $display("The flood of samples never filled the FIFO");
         sb_errors++;
      end

      // Only a reset clears the sticky flag
      @(posedge clk_in);
      rst_n <= 1'b0;
      repeat (4) @(posedge clk_in);
      rst_n <= 1'b1;
      @(posedge clk_in);
      assert (!overflow && !dv_out) else begin
         $display("mismatch at %0t: overflow %b dv_out %b after reset", $time, overflow, dv_out);
         sb_errors++;
      end

      chk_errors = uut.u_dispatch.u_chk.fail_count;
      $display("Errors: scoreboard %0d, protocol assertions %0d", sb_errors, chk_errors);
      if (sb_errors == 0 && chk_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== verif/dispatch_chk.sv ====
`timescale 1ns/1ps

// Protocol checks on the dispatcher, bound into every instr_dispatch instance
module dispatch_chk import dispatch_pkg::*; (
   input logic                    clk_in,
   input logic                    rst_n,
   input logic                    fifo_valid,
   input logic [w_src-1:0]        fifo_src,
   input logic [n_chan*w_sel-1:0] src_sel_flat,
   input logic [n_chan-1:0]       chan_en,
   input logic                    fifo_pop,
   input logic                    dv_out,
   input logic [w_chan:0]         chan_out
);

   // Number of failed checks, read by the testbench at the end of the run
   int fail_count = 0;

   // Channels already issued for the sample at the head of the FIFO
   logic [n_chan-1:0] seen;

   // Channels whose select names the source of the head sample
   logic [n_chan-1:0] routed;

   // The channel on chan_out this cycle as a one-hot mask
   logic [n_chan-1:0] cur_mask;

   logic [w_chan-1:0] out_idx;
   logic [w_src:0]    out_sel;

   assign out_idx = chan_out[w_chan-1:0];
   assign out_sel = src_sel_flat[out_idx*w_sel +: w_sel];

   always_comb begin
      for (int i = 0; i < n_chan; i++) begin
         routed[i] = (src_sel_flat[i*w_sel +: w_sel] == {1'b0, fifo_src});
      end
   end

   assign cur_mask = (chan_out == null_chan) ? '0 : (n_chan'(1) << out_idx);

   // The head stays put until the pop cycle, so a pop or an empty queue ends the sample
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         seen <= '0;
      end else if (!fifo_valid || fifo_pop) begin
         seen <= '0;
      end else if (chan_out != null_chan) begin
         seen[out_idx] <= 1'b1;
      end
   end

   // ------------------------------
   // Output instruction
   // ------------------------------

   a_chan_range: assert property (@(posedge clk_in) disable iff (!rst_n)
      dv_out |-> !chan_out[w_chan])
      else begin
         $error("dv_out raised with the null channel");
         fail_count++;
      end

   a_chan_enabled: assert property (@(posedge clk_in) disable iff (!rst_n)
      dv_out |-> chan_en[out_idx])
      else begin
         $error("dv_out raised for disabled channel %0d", out_idx);
         fail_count++;
      end

   // The head sample is still present while its instructions come out
   a_chan_routed: assert property (@(posedge clk_in) disable iff (!rst_n)
      dv_out |-> (out_sel == {1'b0, fifo_src}))
      else begin
         $error("channel %0d is not routed to source %0d", out_idx, fifo_src);
         fail_count++;
      end

   a_no_repeat: assert property (@(posedge clk_in) disable iff (!rst_n)
      (chan_out != null_chan) |-> !seen[out_idx])
      else begin
         $error("channel %0d issued twice for one sample", out_idx);
         fail_count++;
      end

   a_idle: assert property (@(posedge clk_in) disable iff (!rst_n)
      !fifo_valid |=> !dv_out)
      else begin
         $error("dv_out raised after an empty queue");
         fail_count++;
      end

   // ------------------------------
   // FIFO pop
   // ------------------------------

   // In the pop cycle the last routed channel is still on chan_out
   a_pop_done: assert property (@(posedge clk_in) disable iff (!rst_n)
      fifo_pop |-> (fifo_valid && ((routed & ~(seen | cur_mask)) == '0)))
      else begin
         $error("fifo_pop raised on an empty FIFO or before all routed channels");
         fail_count++;
      end

   // Back-to-back pops only happen when the new head is routed nowhere
   a_pop_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
      fifo_pop |=> (!fifo_pop || (routed == '0)))
      else begin
         $error("fifo_pop held high for a head with routed channels");
         fail_count++;
      end

endmodule

// ==== source/dispatch_top.sv ====
`timescale 1ns/1ps

// Dispatch stage in front of the multichannel PID pipeline
// Samples queue in the FIFO, the routing memory says which channels want
// each source, and the dispatcher turns every sample into instructions
module dispatch_top import dispatch_pkg::*; (
   input  logic                 clk_in,
   input  logic                 rst_n,
   input  logic                 dv_in,
   input  logic [w_src-1:0]     src_in,
   input  logic [w_data-1:0]    data_in,
   input  logic                 wr_en,
   input  logic [w_wr_addr-1:0] wr_addr,
   input  logic [w_chan-1:0]    wr_chan,
   input  logic [w_wr_data-1:0] wr_data,
   output logic                 dv_out,
   output logic [w_chan:0]      chan_out,
   output logic [w_data-1:0]    data_out,
   output logic                 overflow
);

   // ------------------------------
   // FIFO to dispatcher
   // ------------------------------

   logic              fifo_valid;
   logic              fifo_pop;
   logic [w_src-1:0]  fifo_src;
   logic [w_data-1:0] fifo_data;

   // Routing memory to dispatcher
   logic [n_chan*w_sel-1:0] src_sel_flat;
   logic [n_chan-1:0]       chan_en;

   sample_fifo u_fifo (
      .clk_in    (clk_in),
      .rst_n     (rst_n),
      .push      (dv_in),
      .push_src  (src_in),
      .push_data (data_in),
      .pop       (fifo_pop),
      .valid     (fifo_valid),
      .head_src  (fifo_src),
      .head_data (fifo_data),
      .overflow  (overflow)
   );

   route_config u_config (
      .clk_in       (clk_in),
      .rst_n        (rst_n),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_chan      (wr_chan),
      .wr_data      (wr_data),
      .src_sel_flat (src_sel_flat),
      .chan_en      (chan_en)
   );

   instr_dispatch u_dispatch (
      .clk_in       (clk_in),
      .rst_n        (rst_n),
      .fifo_valid   (fifo_valid),
      .fifo_src     (fifo_src),
      .fifo_data    (fifo_data),
      .src_sel_flat (src_sel_flat),
      .chan_en      (chan_en),
      .fifo_pop     (fifo_pop),
      .dv_out       (dv_out),
      .chan_out     (chan_out),
      .data_out     (data_out)
   );

endmodule

// ==== source/instr_dispatch.sv ====
`timescale 1ns/1ps

// Channel decoder for the PID pipeline
// For the sample at the head of the FIFO it issues one instruction per
// output channel routed to that sample's source, lowest channel first, and
// pops the sample once no unsent routed channel is left
module instr_dispatch import dispatch_pkg::*; (
   input  logic                    clk_in,
   input  logic                    rst_n,
   input  logic                    fifo_valid,
   input  logic [w_src-1:0]        fifo_src,
   input  logic [w_data-1:0]       fifo_data,
   input  logic [n_chan*w_sel-1:0] src_sel_flat,
   input  logic [n_chan-1:0]       chan_en,
   output logic                    fifo_pop,
   output logic                    dv_out,
   output logic [w_chan:0]         chan_out,
   output logic [w_data-1:0]       data_out
);

   // ------------------------------
   // Channel match
   // ------------------------------

   // Channels already served for the current head sample
   logic [n_chan-1:0] sent;

   // Channels routed to the head's source and not yet served
   logic [n_chan-1:0] pending;

   logic [w_chan:0]   next_chan;
   logic [w_chan-1:0] next_idx;
   logic              found;

   // The head source is widened with a zero top bit, so null_src never matches
   always_comb begin
      for (int i = 0; i < n_chan; i++) begin
         pending[i] = (src_sel_flat[i*w_sel +: w_sel] == {1'b0, fifo_src}) && !sent[i];
      end
   end

   // Priority encoder, walking down so the lowest pending channel wins
   always_comb begin
      next_chan = null_chan;
      for (int i = n_chan - 1; i >= 0; i--) begin
         if (pending[i]) begin
            next_chan = (w_chan + 1)'(i);
         end
      end
   end

   // The top bit is only set for null_chan
   assign found    = !next_chan[w_chan];
   assign next_idx = next_chan[w_chan-1:0];

   // Nothing left to send for a valid head, so the FIFO drops it on the next edge
   assign fifo_pop = fifo_valid && !found;

   // ------------------------------
   // Decision register
   // ------------------------------

   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         sent     <= '0;
         dv_out   <= 1'b0;
         chan_out <= null_chan;
      end else if (fifo_valid && found) begin
         // A disabled channel burns this cycle without a strobe
         sent[next_idx] <= 1'b1;
         dv_out         <= chan_en[next_idx];
         chan_out       <= next_chan;
      end else begin
         // An empty queue or a pop cycle leaves the map clear and the output idle
         sent     <= '0;
         dv_out   <= 1'b0;
         chan_out <= null_chan;
      end
   end

   // Sample word follows the instruction it belongs to
   always_ff @(posedge clk_in) begin
      if (fifo_valid && found) begin
         data_out <= fifo_data;
      end
   end

endmodule

// ==== source/route_config.sv ====
`timescale 1ns/1ps

// Per-channel routing memory
// Each output channel holds the source it listens to and an enable bit
module route_config import dispatch_pkg::*; (
   input  logic                    clk_in,
   input  logic                    rst_n,
   input  logic                    wr_en,
   input  logic [w_wr_addr-1:0]    wr_addr,
   input  logic [w_chan-1:0]       wr_chan,
   input  logic [w_wr_data-1:0]    wr_data,
   output logic [n_chan*w_sel-1:0] src_sel_flat,
   output logic [n_chan-1:0]       chan_en
);

   // ------------------------------
   // Source select memory
   // ------------------------------

   logic [w_src:0] src_sel [n_chan];

   // Address decode for the two register kinds
   logic sel_wr;
   logic en_wr;

   assign sel_wr = wr_en && (wr_addr == src_sel_addr);
   assign en_wr  = wr_en && (wr_addr == chan_en_addr);

   // All channels start out routed to nothing
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         for (int i = 0; i < n_chan; i++) begin
            src_sel[i] <= null_src;
         end
      end else if (sel_wr) begin
         // Only the low w_src+1 bits of the write word are kept
         src_sel[wr_chan] <= wr_data[w_src:0];
      end
   end

   // ------------------------------
   // Enable bits
   // ------------------------------

   // A disabled channel still takes its slot in the dispatcher
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         chan_en <= '0;
      end else if (en_wr) begin
         chan_en[wr_chan] <= wr_data[0];
      end
   end

   // Flatten the select array so it can cross the port as one vector
   always_comb begin
      for (int i = 0; i < n_chan; i++) begin
         src_sel_flat[i*w_sel +: w_sel] = src_sel[i];
      end
   end

endmodule

// ==== source/sample_fifo.sv ====
`timescale 1ns/1ps

// Show-ahead FIFO for incoming ADC samples
// The head entry is visible on head_src and head_data whenever valid is high
module sample_fifo import dispatch_pkg::*; (
   input  logic              clk_in,
   input  logic              rst_n,
   input  logic              push,
   input  logic [w_src-1:0]  push_src,
   input  logic [w_data-1:0] push_data,
   input  logic              pop,
   output logic              valid,
   output logic [w_src-1:0]  head_src,
   output logic [w_data-1:0] head_data,
   output logic              overflow
);

   // ------------------------------
   // Storage and pointers
   // ------------------------------

   // Source and data of each entry are kept side by side
   logic [w_src-1:0]  mem_src  [fifo_depth];
   logic [w_data-1:0] mem_data [fifo_depth];

   logic [w_ptr-1:0]   wr_ptr;
   logic [w_ptr-1:0]   rd_ptr;
   logic [w_count-1:0] count;

   logic full;
   logic do_push;
   logic do_pop;

   assign full  = (count == w_count'(fifo_depth));
   assign valid = (count != '0);

   // A push into a full buffer is dropped, the pop side never sees it
   assign do_push = push && !full;

   // Popping an empty buffer does nothing
   assign do_pop = pop && valid;

   // Head of the queue is read straight out of the array
   assign head_src  = mem_src[rd_ptr];
   assign head_data = mem_data[rd_ptr];

   // ------------------------------
   // Write side
   // ------------------------------

   always_ff @(posedge clk_in) begin
      if (do_push) begin
         mem_src[wr_ptr]  <= push_src;
         mem_data[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap naturally since fifo_depth is a power of two
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Push and pop together leave the occupancy unchanged
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   // Overflow is sticky until the next reset
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         overflow <= 1'b0;
      end else if (push && full) begin
         overflow <= 1'b1;
      end
   end

endmodule

// ==== source/dispatch_pkg.sv ====
// Shared constants for the PID dispatch stage

package dispatch_pkg;

   // ------------------------------
   // Sample and channel widths
   // ------------------------------

   // Width of an ADC source number
   localparam int w_src = 5;

   // Width of one ADC sample word
   localparam int w_data = 18;

   // Number of output channels served by the dispatcher
   localparam int n_chan = 8;

   // Width of a channel number, the null channel adds one bit on top
   localparam int w_chan = 3;

   // A source-select entry carries one extra bit so it can name no source at all
   localparam int w_sel = w_src + 1;

   // Source select that matches no incoming source
   localparam logic [w_src:0] null_src = {1'b1, {w_src{1'b0}}};

   // Decoder result meaning that no unsent routed channel is left
   localparam logic [w_chan:0] null_chan = {1'b1, {w_chan{1'b0}}};

   // ------------------------------
   // Input FIFO
   // ------------------------------

   // Number of queued samples before overflow
   localparam int fifo_depth = 16;

   // Pointer width into the circular buffer
   localparam int w_ptr = $clog2(fifo_depth);

   // Occupancy counter needs one more bit to reach fifo_depth
   localparam int w_count = w_ptr + 1;

   // ------------------------------
   // Configuration port
   // ------------------------------

   localparam int w_wr_addr = 16;
   localparam int w_wr_data = 16;

   // Register address that writes a channel's source select
   localparam logic [w_wr_addr-1:0] src_sel_addr = 16'd1;

   // Register address that writes a channel's enable bit
   localparam logic [w_wr_addr-1:0] chan_en_addr = 16'd2;

endpackage
